//--- source/ppu_pkg.sv
package ppu_pkg;

  // ********************************************************************
  // Posit format of 16 bits with es = 1
  // ********************************************************************

  localparam int N       = 16;
  localparam int ES      = 1;
  localparam int TE_BITS = 7;  // Covers regime and exponent

  typedef logic signed [TE_BITS-1:0] exponent_t;

  localparam int MANT_SIZE            = 14;  // Hidden bit included
  localparam int MAX_TE_DIFF          = 14;
  localparam int MANT_ADD_RESULT_SIZE = MANT_SIZE + MAX_TE_DIFF + 1;
  localparam int MANT_SUB_RESULT_SIZE = MANT_SIZE + MAX_TE_DIFF;

  // Largest and smallest total exponent a posit can carry
  localparam int MAX_TE = (N - 2) << ES;
  localparam int MIN_TE = -((N - 2) << ES);

  localparam logic [N-1:0] NAR_PATTERN = {1'b1, {(N-1){1'b0}}};
  localparam logic [N-1:0] MAXPOS      = {1'b0, {(N-1){1'b1}}};
  localparam logic [N-1:0] MINPOS      = {{(N-1){1'b0}}, 1'b1};

  function automatic int max(input int a, input int b);
    int result;
    result = (a > b) ? a : b;
    return result;
  endfunction

endpackage

//--- source/apb_map_pkg.sv
package apb_map_pkg;

  localparam int APB_ADDR_W = 5;

  localparam logic [APB_ADDR_W-1:0] ADDR_OP_A   = 5'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_OP_B   = 5'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 5'h08;
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 5'h0C;
  localparam logic [APB_ADDR_W-1:0] ADDR_RESULT = 5'h10;

  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_SUB_BIT    = 1;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

endpackage

//--- source/posit_decode.sv
`timescale 1ns/10ps

module posit_decode
  import ppu_pkg::*;
(
  input  logic [N-1:0]         posit_i,
  output logic                 sign_o,
  output exponent_t            te_o,
  output logic [MANT_SIZE-1:0] mant_o,
  output logic                 is_zero_o,
  output logic                 is_nar_o
);

  logic [N-1:0] abs_val;
  logic [N-2:0] tail;
  logic         regime_bit;
  logic [4:0]   run_len;
  exponent_t    k;

  assign sign_o     = posit_i[N-1];
  assign abs_val    = sign_o ? -posit_i : posit_i;
  assign regime_bit = abs_val[N-2];

  // Length of the regime run
  always_comb begin : count_run
    logic stop;
    stop    = 1'b0;
    run_len = '0;
    for (int i = N - 2; i >= 0; i--) begin
      if (!stop && (abs_val[i] == regime_bit)) begin
        run_len = run_len + 1'b1;
      end else begin
        stop = 1'b1;
      end
    end
  end

  // Drop regime and terminator
  assign tail = abs_val[N-2:0] << (run_len + 1'b1);

  assign k = regime_bit ? exponent_t'(run_len) - exponent_t'(1) : -exponent_t'(run_len);

  assign te_o   = (k <<< ES) + exponent_t'(tail[N-2 -: ES]);
  assign mant_o = {1'b1, tail[N-2-ES -: MANT_SIZE-1]};  // Hidden bit on top

  assign is_zero_o = (posit_i == '0);
  assign is_nar_o  = (posit_i == NAR_PATTERN);

endmodule

//--- source/core_add.sv
`timescale 1ns/10ps

module core_add
  import ppu_pkg::*;
(
  input  logic [MANT_ADD_RESULT_SIZE-1:0] mant_i,
  input  exponent_t                       te_diff_i,
  output logic [MANT_ADD_RESULT_SIZE-1:0] new_mant_o,
  output exponent_t                       new_te_diff_o,
  output logic                            frac_truncated_o
);

  logic carry;

  assign carry = mant_i[MANT_ADD_RESULT_SIZE-1];

  // Carry moves the hidden bit up one place
  assign new_mant_o       = carry ? (mant_i >> 1) : mant_i;
  assign new_te_diff_o    = carry ? te_diff_i + exponent_t'(1) : te_diff_i;
  assign frac_truncated_o = carry & mant_i[0];  // Lost LSB

endmodule

//--- source/core_sub.sv
`timescale 1ns/10ps

module core_sub
  import ppu_pkg::*;
(
  input  logic [MANT_SUB_RESULT_SIZE-1:0] mant_i,
  input  exponent_t                       te_diff_i,
  output logic [MANT_SUB_RESULT_SIZE-1:0] new_mant_o,
  output exponent_t                       new_te_diff_o
);

  localparam int LZ_W = $clog2(MANT_SUB_RESULT_SIZE + 1);

  logic [LZ_W-1:0] lz;

  // Leading zero count that reaches full width when all zero
  always_comb begin : lzc
    logic found;
    found = 1'b0;
    lz    = '0;
    for (int i = MANT_SUB_RESULT_SIZE - 1; i >= 0; i--) begin
      if (!found && !mant_i[i]) begin
        lz = lz + 1'b1;
      end else begin
        found = 1'b1;
      end
    end
  end

  assign new_mant_o    = mant_i << lz;
  assign new_te_diff_o = te_diff_i - exponent_t'(lz);

endmodule

//--- source/core_add_sub.sv
`timescale 1ns/10ps

module core_add_sub
  import ppu_pkg::*;
#(
  parameter int PIPELINE_STAGE = 1
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  exponent_t                       te1_i,
  input  exponent_t                       te2_i,
  input  logic [MANT_SIZE-1:0]            mant1_i,
  input  logic [MANT_SIZE-1:0]            mant2_i,
  input  logic                            have_opposite_sign_i,
  output logic [MANT_ADD_RESULT_SIZE-1:0] mant_o,
  output exponent_t                       te_o,
  output logic                            frac_truncated_o
);

  localparam int UP_W = MANT_SIZE + MAX_TE_DIFF;

  exponent_t                       te_diff_st0, te_diff_st1, te2_st1;
  logic [UP_W-1:0]                 mant1_up, mant2_up, mant2_addend;
  logic [MANT_ADD_RESULT_SIZE-1:0] mant_sum_st0, mant_sum_st1;
  logic                            opp_st1;
  int                              shift_amt;

  logic [MANT_ADD_RESULT_SIZE-1:0] add_mant;
  exponent_t                       add_te_diff;
  logic                            add_trunc;
  logic [MANT_SUB_RESULT_SIZE-1:0] sub_mant;
  exponent_t                       sub_te_diff;

  assign te_diff_st0 = te1_i - te2_i;
  assign shift_amt   = (te_diff_st0 > MAX_TE_DIFF) ? MAX_TE_DIFF : max(0, te_diff_st0);

  assign mant1_up     = {mant1_i, {MAX_TE_DIFF{1'b0}}};
  assign mant2_up     = {mant2_i, {MAX_TE_DIFF{1'b0}}} >> shift_amt;
  assign mant2_addend = have_opposite_sign_i ? ~mant2_up + 1'b1 : mant2_up;
  assign mant_sum_st0 = mant1_up + mant2_addend;  // Top bit is the add carry

  // ********************************************************************
  // Optional stage before renormalization
  // ********************************************************************

  if (PIPELINE_STAGE != 0) begin : g_stage
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        opp_st1 <= 1'b0;
      end else begin
        opp_st1 <= have_opposite_sign_i;
      end
    end

    always_ff @(posedge clk_i) begin
      te_diff_st1  <= te_diff_st0;
      mant_sum_st1 <= mant_sum_st0;
      te2_st1      <= te2_i;
    end
  end else begin : g_comb
    assign opp_st1      = have_opposite_sign_i;
    assign te_diff_st1  = te_diff_st0;
    assign mant_sum_st1 = mant_sum_st0;
    assign te2_st1      = te2_i;
  end

  core_add u_core_add (
    .mant_i           (mant_sum_st1),
    .te_diff_i        (te_diff_st1),
    .new_mant_o       (add_mant),
    .new_te_diff_o    (add_te_diff),
    .frac_truncated_o (add_trunc)
  );

  core_sub u_core_sub (
    .mant_i        (mant_sum_st1[MANT_SUB_RESULT_SIZE-1:0]),  // Borrow bit dropped
    .te_diff_i     (te_diff_st1),
    .new_mant_o    (sub_mant),
    .new_te_diff_o (sub_te_diff)
  );

  assign mant_o           = opp_st1 ? {1'b0, sub_mant} : add_mant;
  assign te_o             = te2_st1 + (opp_st1 ? sub_te_diff : add_te_diff);
  assign frac_truncated_o = ~opp_st1 & add_trunc;

endmodule

//--- source/posit_encode.sv
`timescale 1ns/10ps

module posit_encode
  import ppu_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            valid_i,
  input  logic                            sign_i,
  input  exponent_t                       te_i,
  input  logic [MANT_ADD_RESULT_SIZE-1:0] mant_i,
  input  logic                            frac_truncated_i,
  output logic [N-1:0]                    result_o,
  output logic                            valid_o
);

  localparam int FRAC_W = MANT_ADD_RESULT_SIZE - 2;  // Bits below the hidden bit
  localparam int BODY_W = 2 + ES + FRAC_W + N - 2;
  localparam int SH_W   = $clog2(N);

  exponent_t                 k;
  logic [ES-1:0]             exp_bits;
  logic signed [BODY_W-1:0]  body, shifted;
  logic [SH_W-1:0]           reg_shift;
  logic [N-2:0]              mag, mag_rounded, mag_final;
  logic                      guard, sticky, round_up;
  logic [N-1:0]              result_d;

  assign k        = te_i >>> ES;
  assign exp_bits = te_i[ES-1:0];

  // Seed 10 or 01 that the arithmetic shift extends into the regime run
  assign body      = {~k[TE_BITS-1], k[TE_BITS-1], exp_bits, mant_i[FRAC_W-1:0],
                      {(N-2){1'b0}}};
  assign reg_shift = k[TE_BITS-1] ? SH_W'(~k) : SH_W'(k);
  assign shifted   = body >>> reg_shift;

  // ********************************************************************
  // Round to nearest even
  // ********************************************************************

  assign mag         = shifted[BODY_W-1 -: N-1];
  assign guard       = shifted[BODY_W-N];
  assign sticky      = (|shifted[BODY_W-N-1:0]) | frac_truncated_i;
  assign round_up    = guard & (mag[0] | sticky);
  assign mag_rounded = mag + round_up;

  always_comb begin
    if (te_i > MAX_TE) begin
      mag_final = MAXPOS[N-2:0];
    end else if (te_i < MIN_TE) begin
      mag_final = MINPOS[N-2:0];  // Never rounds to zero
    end else begin
      mag_final = mag_rounded;
    end
  end

  assign result_d = (mant_i == '0) ? '0 : (sign_i ? -{1'b0, mag_final} : {1'b0, mag_final});

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= result_d;
    end
  end

endmodule

//--- source/ppu_adder.sv
`timescale 1ns/10ps

module ppu_adder
  import ppu_pkg::*;
#(
  parameter int PIPELINE_STAGE = 1
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         start_i,
  input  logic         sub_i,
  input  logic [N-1:0] op_a_i,
  input  logic [N-1:0] op_b_i,
  output logic [N-1:0] result_o,
  output logic         valid_o
);

  localparam int SIDE_D = PIPELINE_STAGE + 1;  // Stages up to encoder input

  logic                 sign_a, sign_b, zero_a, zero_b, nar_a, nar_b, a_larger;
  exponent_t            te_a, te_b, te1_q, te2_q, te_sum;
  logic [MANT_SIZE-1:0] mant_a, mant_b, mant1_q, mant2_q;
  logic                 opp_q, special_d, sign_d, trunc;
  logic [N-1:0]         special_val_d, enc_result;
  logic [SIDE_D-1:0]    vld_q, sign_q;
  logic [SIDE_D:0]      spec_q;
  logic [N-1:0]         spec_val_q [SIDE_D+1];
  logic [MANT_ADD_RESULT_SIZE-1:0] mant_sum;

  posit_decode u_dec_a (
    .posit_i (op_a_i), .sign_o (sign_a), .te_o (te_a), .mant_o (mant_a),
    .is_zero_o (zero_a), .is_nar_o (nar_a)
  );

  posit_decode u_dec_b (
    .posit_i (op_b_i), .sign_o (sign_b), .te_o (te_b), .mant_o (mant_b),
    .is_zero_o (zero_b), .is_nar_o (nar_b)
  );

  assign a_larger = (te_a > te_b) || ((te_a == te_b) && (mant_a >= mant_b));
  assign sign_d   = a_larger ? sign_a : (sign_b ^ sub_i);

  always_comb begin
    special_d     = 1'b1;
    special_val_d = '0;
    if (nar_a || nar_b) begin
      special_val_d = NAR_PATTERN;
    end else if (zero_a) begin
      special_val_d = sub_i ? -op_b_i : op_b_i;
    end else if (zero_b) begin
      special_val_d = op_a_i;
    end else begin
      special_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      te1_q   <= a_larger ? te_a : te_b;
      te2_q   <= a_larger ? te_b : te_a;
      mant1_q <= a_larger ? mant_a : mant_b;
      mant2_q <= a_larger ? mant_b : mant_a;
      opp_q   <= sign_a ^ sign_b ^ sub_i;  // Effective subtract
    end
  end

  // Side pipeline for valid, sign and special results
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= SIDE_D'({vld_q, start_i});
    end
  end

  always_ff @(posedge clk_i) begin
    sign_q        <= SIDE_D'({sign_q, sign_d});
    spec_q        <= (SIDE_D + 1)'({spec_q, special_d});
    spec_val_q[0] <= special_val_d;
    for (int i = 1; i <= SIDE_D; i++) begin
      spec_val_q[i] <= spec_val_q[i-1];
    end
  end

  core_add_sub #(
    .PIPELINE_STAGE (PIPELINE_STAGE)
  ) u_core_add_sub (
    .clk_i (clk_i), .rst_i (rst_i),
    .te1_i (te1_q), .te2_i (te2_q), .mant1_i (mant1_q), .mant2_i (mant2_q),
    .have_opposite_sign_i (opp_q),
    .mant_o (mant_sum), .te_o (te_sum), .frac_truncated_o (trunc)
  );

  posit_encode u_encode (
    .clk_i (clk_i), .rst_i (rst_i), .valid_i (vld_q[SIDE_D-1]),
    .sign_i (sign_q[SIDE_D-1]), .te_i (te_sum), .mant_i (mant_sum),
    .frac_truncated_i (trunc), .result_o (enc_result), .valid_o (valid_o)
  );

  assign result_o = spec_q[SIDE_D] ? spec_val_q[SIDE_D] : enc_result;

endmodule

//--- source/ppu_apb_top.sv
`timescale 1ns/10ps

module ppu_apb_top
  import ppu_pkg::*, apb_map_pkg::*;
#(
  parameter int PIPELINE_STAGE = 1
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [31:0]           pwdata_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  logic [N-1:0] op_a_q, op_b_q, result_q, adder_result;
  logic         busy_q, done_q, sub_q, start, adder_valid;
  logic         access, wr_en, addr_hit;

  assign access   = psel_i & penable_i;
  assign wr_en    = access & pwrite_i;
  assign addr_hit = paddr_i inside {ADDR_OP_A, ADDR_OP_B, ADDR_CTRL, ADDR_STATUS, ADDR_RESULT};

  assign pready_o  = 1'b1;  // No wait states
  assign pslverr_o = access & ~addr_hit;

  assign start = wr_en && (paddr_i == ADDR_CTRL) && pwdata_i[CTRL_START_BIT] && !busy_q;

  always_ff @(posedge clk_i) begin
    if (wr_en && (paddr_i == ADDR_OP_A)) begin
      op_a_q <= pwdata_i[N-1:0];
    end
    if (wr_en && (paddr_i == ADDR_OP_B)) begin
      op_b_q <= pwdata_i[N-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      sub_q    <= 1'b0;
      result_q <= '0;
    end else begin
      if (start) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
        sub_q  <= pwdata_i[CTRL_SUB_BIT];
      end
      if (adder_valid) begin
        busy_q   <= 1'b0;
        done_q   <= 1'b1;
        result_q <= adder_result;
      end
    end
  end

  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      ADDR_OP_A:   prdata_o[N-1:0] = op_a_q;
      ADDR_OP_B:   prdata_o[N-1:0] = op_b_q;
      ADDR_CTRL:   prdata_o[CTRL_SUB_BIT] = sub_q;
      ADDR_STATUS: begin
        prdata_o[STATUS_BUSY_BIT] = busy_q;
        prdata_o[STATUS_DONE_BIT] = done_q;
      end
      ADDR_RESULT: prdata_o[N-1:0] = result_q;
      default:     prdata_o = '0;
    endcase
  end

  ppu_adder #(
    .PIPELINE_STAGE (PIPELINE_STAGE)
  ) u_ppu_adder (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (start),
    .sub_i    (pwdata_i[CTRL_SUB_BIT]),  // Sampled with the start write
    .op_a_i   (op_a_q),
    .op_b_i   (op_b_q),
    .result_o (adder_result),
    .valid_o  (adder_valid)
  );

endmodule

//--- tb/ppu_assertions.sv
`timescale 1ns/10ps

module ppu_assertions
  import apb_map_pkg::*;
(
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  psel_i,
  input logic                  penable_i,
  input logic [APB_ADDR_W-1:0] paddr_i,
  input logic                  pready_i,
  input logic                  pslverr_i,
  input logic                  start_i,
  input logic                  busy_i,
  input logic                  done_i
);

  int   error_count = 0;  // Read by the testbench
  logic in_map;

  assign in_map = paddr_i inside {ADDR_OP_A, ADDR_OP_B, ADDR_CTRL, ADDR_STATUS, ADDR_RESULT};

  // ********************************************************************
  // APB protocol
  // ********************************************************************

  assert property (@(posedge clk_i) disable iff (rst_i)
    (psel_i && penable_i) |-> pready_i)
  else begin
    $error("pready_o low in an access phase");
    error_count++;
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    pslverr_i |-> (psel_i && penable_i && !in_map))
  else begin
    $error("pslverr_o asserted for a mapped address or outside an access phase");
    error_count++;
  end

  // ********************************************************************
  // Busy and done
  // ********************************************************************

  // Done register follows valid_o by one edge
  assert property (@(posedge clk_i) disable iff (rst_i)
    start_i |=> !done_i ##1 !done_i ##1 !done_i ##1 done_i)
  else begin
    $error("done did not rise at the expected cycle after start");
    error_count++;
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(busy_i) |-> $past(start_i))
  else begin
    $error("busy rose without an accepted start");
    error_count++;
  end

endmodule

bind ppu_apb_top ppu_assertions u_ppu_assertions (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .paddr_i   (paddr_i),
  .pready_i  (pready_o),
  .pslverr_i (pslverr_o),
  .start_i   (start),
  .busy_i    (busy_q),
  .done_i    (done_q)
);

//--- tb/ppu_tb.sv
`timescale 1ns/10ps

module ppu_tb
  import ppu_pkg::*, apb_map_pkg::*;
();

  localparam int          CLK_PERIOD   = 10;
  localparam int          SAMPLE_DELAY = 2;  // Into the low clock phase
  localparam int          NUM_RANDOM   = 12;
  localparam int          NUM_OPS      = 8 + 6 * NUM_RANDOM;
  localparam int          CYCLE_LIMIT  = 40 * NUM_OPS + 100;
  localparam logic [31:0] LCG_SEED     = 32'hc5e0_46a2;
  localparam logic [31:0] CMD_ADD      = 32'(1) << CTRL_START_BIT;
  localparam logic [31:0] CMD_SUB      = CMD_ADD | (32'(1) << CTRL_SUB_BIT);

  logic                  clk, rst, psel, penable, pwrite, pready, pslverr;
  logic [APB_ADDR_W-1:0] paddr;
  logic [31:0]           pwdata, prdata;
  logic [31:0]           lcg_state;
  int                    cycle_count = 0;

  ppu_apb_top #(
    .PIPELINE_STAGE (1)
  ) dut_i (
    .clk_i     (clk),
    .rst_i     (rst),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      fail_run($sformatf("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_operand(output logic [N-1:0] x);
    lcg_state = lcg_step(lcg_state);
    x = lcg_state[31:16];
    if (x == NAR_PATTERN) begin
      x = x ^ 16'h0001;  // x - x must stay a real
    end
  endtask

  // ********************************************************************
  // APB master started on a falling edge
  // ********************************************************************

  task automatic apb_transfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #SAMPLE_DELAY;
    rdata = prdata;
    err   = pslverr;
    check_value("pready_o", pready, 1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    apb_transfer(1'b1, addr, data, unused, err);
    check_value("pslverr_o", err, 0);
  endtask

  task automatic read_reg(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
    logic err;
    apb_transfer(1'b0, addr, '0, data, err);
    check_value("pslverr_o", err, 0);
  endtask

  task automatic wait_done();
    logic [31:0] status;
    status = '0;
    while (!status[STATUS_DONE_BIT]) begin
      read_reg(ADDR_STATUS, status);
    end
    check_value("status.busy", status[STATUS_BUSY_BIT], 0);
  endtask

  task automatic run_op(input logic [N-1:0] a, input logic [N-1:0] b, input logic sub,
                        output logic [N-1:0] res);
    logic [31:0] rdata;
    write_reg(ADDR_OP_A, 32'(a));
    write_reg(ADDR_OP_B, 32'(b));
    write_reg(ADDR_CTRL, sub ? CMD_SUB : CMD_ADD);
    wait_done();
    read_reg(ADDR_RESULT, rdata);
    res = rdata[N-1:0];
    read_reg(ADDR_STATUS, rdata);  // Done stays set after a read
    check_value("status.done", rdata[STATUS_DONE_BIT], 1);
    assert (dut_i.u_ppu_assertions.error_count == 0)
    else fail_run("A bound protocol or timing assertion failed");
  endtask

  task automatic check_op(input string what, input logic [N-1:0] a, input logic [N-1:0] b,
                          input logic sub, input logic [N-1:0] exp);
    logic [N-1:0] res;
    run_op(a, b, sub, res);
    check_value($sformatf("result of %s (0x%h %s 0x%h)", what, a, sub ? "-" : "+", b),
                32'(res), 32'(exp));
  endtask

  initial begin
    logic [N-1:0] x, y, r1, r2, neg;
    logic [31:0]  rdata;
    logic         err;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    lcg_state = LCG_SEED;
    rst       = 1'b1;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    read_reg(ADDR_STATUS, rdata);
    check_value("status after reset", rdata, 0);
    read_reg(ADDR_RESULT, rdata);
    check_value("result after reset", rdata, 0);

    // Known encodings
    check_op("1 + 1", 16'h4000, 16'h4000, 1'b0, 16'h5000);
    check_op("3 + 5", 16'h5800, 16'h6200, 1'b0, 16'h6800);
    check_op("2 - 3", 16'h5000, 16'h5800, 1'b1, 16'hc000);
    check_op("0.5 + 0.25", 16'h3000, 16'h2000, 1'b0, 16'h3800);

    check_op("NaR + 1", NAR_PATTERN, 16'h4000, 1'b0, NAR_PATTERN);
    check_op("1 - NaR", 16'h4000, NAR_PATTERN, 1'b1, NAR_PATTERN);
    check_op("maxpos + maxpos", 16'h7fff, 16'h7fff, 1'b0, 16'h7fff);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      draw_operand(x);
      draw_operand(y);
      check_op("x + 0", x, 16'h0000, 1'b0, x);
      check_op("x - x", x, x, 1'b1, 16'h0000);
      run_op(x, y, 1'b0, r1);
      run_op(y, x, 1'b0, r2);
      check_value("result of b + a vs a + b", 32'(r2), 32'(r1));
      run_op(x, y, 1'b1, r1);
      run_op(y, x, 1'b1, r2);
      neg = -r2;
      check_value("result of a - b vs -(b - a)", 32'(r1), 32'(neg));
    end

    // ********************************************************************
    // Bus errors and a start while busy
    // ********************************************************************

    apb_transfer(1'b1, 5'h14, 32'h0, rdata, err);
    check_value("pslverr_o on write to 0x14", err, 1);
    apb_transfer(1'b0, 5'h1c, 32'h0, rdata, err);
    check_value("pslverr_o on read of 0x1c", err, 1);

    write_reg(ADDR_OP_A, 32'h4000);
    write_reg(ADDR_OP_B, 32'h4000);
    write_reg(ADDR_CTRL, CMD_ADD);
    write_reg(ADDR_CTRL, CMD_SUB);  // Lands while busy
    wait_done();
    read_reg(ADDR_RESULT, rdata);
    check_value("result with start while busy", rdata, 32'h5000);
    repeat (10) @(negedge clk);
    read_reg(ADDR_RESULT, rdata);
    check_value("result after idle cycles", rdata, 32'h5000);
    read_reg(ADDR_STATUS, rdata);
    check_value("status after idle cycles", rdata, 32'(1) << STATUS_DONE_BIT);

    if (dut_i.u_ppu_assertions.error_count != 0) begin
      fail_run("A bound protocol or timing assertion failed");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

//--- files.f
source/ppu_pkg.sv
source/apb_map_pkg.sv
source/posit_decode.sv
source/core_add.sv
source/core_sub.sv
source/core_add_sub.sv
source/posit_encode.sv
source/ppu_adder.sv
source/ppu_apb_top.sv
tb/ppu_assertions.sv
tb/ppu_tb.sv
